// File: src/routerPkg.sv
package routerPkg;

  // Inputs of one output port of the mesh router.
  localparam int NumPorts = 5;

  typedef logic [2:0]          portIdx_t;
  typedef logic [NumPorts-1:0] portMask_t;
  typedef logic [2:0]          flitKind_t;
  // Extra cycles an input may hold the output after its grant.
  typedef logic [11:0]         pktLen_t;

  localparam portIdx_t PortLocal = 3'd0;
  localparam portIdx_t PortNorth = 3'd1;
  localparam portIdx_t PortEast  = 3'd2;
  localparam portIdx_t PortWest  = 3'd3;
  localparam portIdx_t PortSouth = 3'd4;

  localparam flitKind_t KindNone = 3'd0;
  localparam flitKind_t KindHead = 3'd1;
  localparam flitKind_t KindBody = 3'd2;
  localparam flitKind_t KindTail = 3'd3;

  // Data words travel beside these structs as separate vectors.
  typedef struct packed {
    logic      req;
    flitKind_t kind;
    pktLen_t   len;
  } inFlit_t;

  typedef struct packed {
    logic      valid;
    flitKind_t kind;
  } outFlit_t;

  // One-hot states with bit 0 for idle and bits 1 to 5 following the port indices.
  typedef enum logic [5:0] {
    StIdle  = 6'b000001,
    StLocal = 6'b000010,
    StNorth = 6'b000100,
    StEast  = 6'b001000,
    StWest  = 6'b010000,
    StSouth = 6'b100000
  } arbState_t;

endpackage

// File: src/holdTimer.sv
`timescale 1ns/1ps

module holdTimer
  import routerPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  flitKind_t kind,
  input  pktLen_t   len,
  input  logic      runTimer,
  output logic      timesUp
);

  pktLen_t limit;
  pktLen_t count;

  // The limit follows every header on this input, granted or not.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (kind == KindHead)
    begin
      limit <= len;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (!runTimer)
    begin
      count <= '0;
    end
    else
    begin
      count <= count + pktLen_t'(1);
    end
  end

  assign timesUp = (count == limit);

  // The arbiter stops the timer once it reaches the limit.
  assert property (@(posedge clk) disable iff (rst) runTimer |-> count <= limit)
    else $error("holdTimer count passed its limit");

endmodule

// File: src/portArbiter.sv
`timescale 1ns/1ps

module portArbiter
  import routerPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t req,
  input  portMask_t timesUp,
  output portMask_t runTimer,
  output portMask_t grant
);

  arbState_t state;
  arbState_t nextState;
  portIdx_t  holder;
  portIdx_t  startAfter;
  portMask_t keepMask;

  // First requester in cyclic order from start among span inputs.
  function automatic portMask_t pickFirst(
    input portMask_t   mask,
    input portIdx_t    start,
    input int unsigned span
  );
    portMask_t   pick;
    int unsigned idx;
    pick = '0;
    for (int unsigned k = 0; k < span; k++)
    begin
      idx = (int'(start) + k) % NumPorts;
      if (pick == '0 && mask[idx])
      begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic arbState_t toState(input portMask_t pick);
    arbState_t st;
    if (pick == '0)
    begin
      st = StIdle;
    end
    else
    begin
      st = arbState_t'({pick, 1'b0});
    end
    return st;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= StIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state[NumPorts:1];

  // Index of the input that holds the output.
  always_comb
  begin
    holder = PortLocal;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i])
      begin
        holder = portIdx_t'(i);
      end
    end
  end

  assign startAfter = (holder == PortSouth) ? PortLocal : holder + 3'd1;
  assign keepMask   = grant & req & ~timesUp;

  always_comb
  begin
    runTimer  = '0;
    nextState = StIdle;
    case (state)
      StIdle:
      begin
        nextState = toState(pickFirst(req, PortLocal, NumPorts));
      end
      StLocal, StNorth, StEast, StWest, StSouth:
      begin
        if (keepMask != '0)
        begin
          // Holder still requests and its hold time is not over.
          runTimer  = grant;
          nextState = state;
        end
        else
        begin
          nextState = toState(pickFirst(req, startAfter, NumPorts - 1));
        end
      end
      default:
      begin
        nextState = StIdle;
      end
    endcase
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant is not one-hot");

  assert property (@(posedge clk) disable iff (rst) (runTimer & ~grant) == '0)
    else $error("runTimer strobes an input without grant");

endmodule

// File: src/flitSwitch.sv
`timescale 1ns/1ps

module flitSwitch
  import routerPkg::*;
#(
  parameter int DataWidth = 32
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  portMask_t            grant,
  input  inFlit_t              inFlit [NumPorts],
  input  logic [DataWidth-1:0] inData [NumPorts],
  output outFlit_t             outFlit,
  output logic [DataWidth-1:0] outData
);

  flitKind_t            selKind;
  logic [DataWidth-1:0] selData;
  logic                 anyGrant;

  // And-or multiplexer over a one-hot or zero grant.
  always_comb
  begin
    selKind = KindNone;
    selData = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i])
      begin
        selKind = selKind | inFlit[i].kind;
        selData = selData | inData[i];
      end
    end
  end

  assign anyGrant = |grant;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit.valid <= 1'b0;
      outFlit.kind  <= KindNone;
      outData       <= '0;
    end
    else if (anyGrant)
    begin
      outFlit.valid <= 1'b1;
      outFlit.kind  <= selKind;
      outData       <= selData;
    end
    else
    begin
      // Empty link when nobody holds the output.
      outFlit.valid <= 1'b0;
      outFlit.kind  <= KindNone;
      outData       <= '0;
    end
  end

endmodule

// File: src/outputPort.sv
`timescale 1ns/1ps

module outputPort
  import routerPkg::*;
#(
  parameter int DataWidth = 32
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  inFlit_t              inFlit [NumPorts],
  input  logic [DataWidth-1:0] inData [NumPorts],
  output portMask_t            grant,
  output outFlit_t             outFlit,
  output logic [DataWidth-1:0] outData
);

  portMask_t reqMask;
  portMask_t runTimer;
  portMask_t timesUp;

  // One hold timer per input.
  for (genvar i = 0; i < NumPorts; i++)
  begin : genTimer
    assign reqMask[i] = inFlit[i].req;

    holdTimer u_holdTimer (
      .clk      (clk),
      .rst      (rst),
      .kind     (inFlit[i].kind),
      .len      (inFlit[i].len),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  portArbiter u_portArbiter (
    .clk      (clk),
    .rst      (rst),
    .req      (reqMask),
    .timesUp  (timesUp),
    .runTimer (runTimer),
    .grant    (grant)
  );

  // Registered output link, one cycle behind the grant.
  flitSwitch #(
    .DataWidth (DataWidth)
  ) u_flitSwitch (
    .clk     (clk),
    .rst     (rst),
    .grant   (grant),
    .inFlit  (inFlit),
    .inData  (inData),
    .outFlit (outFlit),
    .outData (outData)
  );

endmodule

// File: bench/outputPortTb.sv
`timescale 1ns/1ps

module outputPortTb
  import routerPkg::*;
();

  localparam int DataWidth   = 32;
  localparam int ClkPeriod   = 100;
  localparam int SampleDelay = 90;
  localparam int MaxCycles   = 200;
  localparam int NumColumns  = 20;

  logic                 clk;
  logic                 rst;
  inFlit_t              inFlit [NumPorts];
  logic [DataWidth-1:0] inData [NumPorts];
  portMask_t            grant;
  outFlit_t             outFlit;
  logic [DataWidth-1:0] outData;

  int seed;

  outputPort #(
    .DataWidth (DataWidth)
  ) u_outputPort (
    .clk     (clk),
    .rst     (rst),
    .inFlit  (inFlit),
    .inData  (inData),
    .grant   (grant),
    .outFlit (outFlit),
    .outData (outData)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  task automatic abortRun();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first failed check");
  endtask

  task automatic checkGrant(input portMask_t expected);
    if (grant !== expected)
    begin
      $display("MISMATCH time %0t grant expected %b actual %b", $time, expected, grant);
      abortRun();
    end
  endtask

  task automatic checkOutFlit(input outFlit_t expected);
    if (outFlit !== expected)
    begin
      $display("MISMATCH time %0t outFlit expected valid %b kind %0d actual valid %b kind %0d",
        $time, expected.valid, expected.kind, outFlit.valid, outFlit.kind);
      abortRun();
    end
  endtask

  task automatic checkData(input logic [DataWidth-1:0] expected);
    if (outData !== expected)
    begin
      $display("MISMATCH time %0t outData expected %h actual %h", $time, expected, outData);
      abortRun();
    end
  endtask

  // Comment and blank lines of the cases file hold no cycle.
  function automatic bit isCaseLine(input string text);
    bit isCase;
    isCase = 1'b1;
    if (text.len() == 0)
    begin
      isCase = 1'b0;
    end
    else if (text.getc(0) == "#" || text.getc(0) == "\n")
    begin
      isCase = 1'b0;
    end
    return isCase;
  endfunction

  initial
  begin
    int                   fd;
    int                   fields;
    int                   lineNo;
    int                   cycleCount;
    bit                   endOfFile;
    string                text;
    portMask_t            reqCol;
    flitKind_t            kindCol [NumPorts];
    pktLen_t              lenCol [NumPorts];
    logic [DataWidth-1:0] dataCol [NumPorts];
    portMask_t            expGrant;
    logic                 expValid;
    flitKind_t            expKind;
    outFlit_t             expFlit;
    logic [DataWidth-1:0] expData;

    seed       = 32'h0c2b4796;
    lineNo     = 0;
    cycleCount = 0;
    endOfFile  = 1'b0;
    rst        = 1'b1;
    for (int i = 0; i < NumPorts; i++)
    begin
      inFlit[i] = '0;
      inData[i] = '0;
    end

    fd = $fopen("bench/outputPortCases.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open bench/outputPortCases.txt for reading");
      abortRun();
    end

    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // One case line per clock cycle, checked just before the next edge.
    while (!endOfFile && cycleCount < MaxCycles)
    begin
      if ($fgets(text, fd) == 0)
      begin
        endOfFile = 1'b1;
      end
      else
      begin
        lineNo++;
        if (isCaseLine(text))
        begin
          fields = $sscanf(text,
            "%b %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %b %h %h %h",
            reqCol, kindCol[0], kindCol[1], kindCol[2], kindCol[3], kindCol[4],
            lenCol[0], lenCol[1], lenCol[2], lenCol[3], lenCol[4],
            dataCol[0], dataCol[1], dataCol[2], dataCol[3], dataCol[4],
            expGrant, expValid, expKind, expData);
          if (fields != NumColumns)
          begin
            $display("Line %0d of the cases file has %0d fields instead of %0d",
              lineNo, fields, NumColumns);
            abortRun();
          end
          expFlit.valid = expValid;
          expFlit.kind  = expKind;

          // Words of inputs without grant never reach the link.
          for (int i = 0; i < NumPorts; i++)
          begin
            if (!expGrant[i])
            begin
              dataCol[i] = $random(seed);
            end
          end

          @(posedge clk);
          for (int i = 0; i < NumPorts; i++)
          begin
            inFlit[i].req  <= reqCol[i];
            inFlit[i].kind <= kindCol[i];
            inFlit[i].len  <= lenCol[i];
            inData[i]      <= dataCol[i];
          end

          #(SampleDelay);
          checkGrant(expGrant);
          checkOutFlit(expFlit);
          checkData(expData);
          cycleCount++;
        end
      end
    end
    $fclose(fd);

    if (endOfFile && cycleCount > 0)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
    begin
      if (cycleCount == 0)
      begin
        $display("The cases file holds no case lines");
      end
      else
      begin
        $display("Cycle limit of %0d reached before the end of the cases file", MaxCycles);
      end
      abortRun();
    end
  end

endmodule

// File: bench/outputPortCases.txt
# req(S..L) kind L N E W S  len L N E W S  data L N E W S  grant(S..L) valid kind data
# Masks are binary with South on the left, every other column is hex.
# Reset and idle.
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000 0 0 0
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000 0 0 0
# N, W and S ask together, N wins and holds for its length plus one.
11010 0 1 0 1 1 0 3 0 1 5 0 0 0 0 0 00000 0 0 0
11010 0 1 0 1 1 0 3 0 1 5 0 a0000001 0 0 0 00010 0 0 0
11010 0 2 0 1 1 0 0 0 1 5 0 a0000002 0 0 0 00010 1 1 a0000001
11010 0 2 0 1 1 0 0 0 1 5 0 a0000003 0 0 0 00010 1 2 a0000002
11010 0 3 0 1 1 0 0 0 1 5 0 a0000004 0 0 0 00010 1 2 a0000003
# W comes next after N and counts from zero.
11000 0 0 0 1 1 0 0 0 1 5 0 0 0 b0000001 0 01000 1 3 a0000004
11000 0 0 0 3 1 0 0 0 0 5 0 0 0 b0000002 0 01000 1 1 b0000001
# S drops its request early and N takes over.
10000 0 0 0 0 1 0 0 0 0 5 0 0 0 0 c0000001 10000 1 3 b0000002
10000 0 0 0 0 3 0 0 0 0 0 0 0 0 0 c0000002 10000 1 1 c0000001
00010 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 10000 1 3 c0000002
00010 0 3 0 0 0 0 0 0 0 0 0 a0000005 0 0 0 00010 1 0 0
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000 1 3 a0000005
# E alone releases before its timer ends, the port goes idle.
00100 0 0 1 0 0 0 0 4 0 0 0 0 0 0 0 00000 0 0 0
00100 0 0 1 0 0 0 0 4 0 0 0 0 d0000001 0 0 00100 0 0 0
00100 0 0 2 0 0 0 0 0 0 0 0 0 d0000002 0 0 00100 1 1 d0000001
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00100 1 2 d0000002
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000 1 0 0
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000 0 0 0
# All five ask with length zero, one cycle each around the ring.
11111 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 00000 0 0 0
11111 2 2 2 2 2 0 0 0 0 0 e0000001 0 0 0 0 00001 0 0 0
11111 2 2 2 2 2 0 0 0 0 0 0 e0000002 0 0 0 00010 1 2 e0000001
11111 2 2 2 2 2 0 0 0 0 0 0 0 e0000003 0 0 00100 1 2 e0000002
11111 2 2 2 2 2 0 0 0 0 0 0 0 0 e0000004 0 01000 1 2 e0000003
11111 2 2 2 2 2 0 0 0 0 0 0 0 0 0 e0000005 10000 1 2 e0000004
11111 2 2 2 2 2 0 0 0 0 0 e0000006 0 0 0 0 00001 1 2 e0000005
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00010 1 2 e0000006
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000 1 0 0
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000 0 0 0
# L holds two extra cycles while E and S wait their turn.
# E loads its header length while it is not granted.
10001 1 0 0 0 1 2 0 0 0 1 0 0 0 0 0 00000 0 0 0
10001 1 0 0 0 1 2 0 0 0 1 f0000001 0 0 0 0 00001 0 0 0
10101 2 0 1 0 1 0 0 2 0 1 f0000002 0 0 0 0 00001 1 1 f0000001
10101 3 0 1 0 1 0 0 2 0 1 f0000003 0 0 0 0 00001 1 2 f0000002
10100 0 0 1 0 1 0 0 2 0 1 0 0 f0000004 0 0 00100 1 3 f0000003
10100 0 0 2 0 1 0 0 0 0 1 0 0 f0000005 0 0 00100 1 1 f0000004
10100 0 0 3 0 1 0 0 0 0 1 0 0 f0000006 0 0 00100 1 2 f0000005
# S wraps back to L.
10000 0 0 0 0 1 0 0 0 0 1 0 0 0 0 f0000007 10000 1 3 f0000006
10001 1 0 0 0 3 0 0 0 0 0 0 0 0 0 f0000008 10000 1 1 f0000007
00001 1 0 0 0 0 0 0 0 0 0 f0000009 0 0 0 0 00001 1 3 f0000008
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000 1 1 f0000009
00000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000 0 0 0

// File: all.f
src/routerPkg.sv
src/holdTimer.sv
src/portArbiter.sv
src/flitSwitch.sv
src/outputPort.sv
bench/outputPortTb.sv

// File: Makefile
TOP = outputPortTb

.PHONY: all lint build sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

sim: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
